/* Bender.yml */
package:
  name: a09_cpu

sources:
  - a09Pkg.sv
  - a09CtrlIf.sv
  - sequenceControl.sv
  - aluExecute.sv
  - fetchStore.sv
  - a09Cpu.sv
  - target: test
    files:
      - a09CpuTb.sv

/* a09Cpu.sv */
`timescale 1ns/1ps

module a09Cpu
    import a09Pkg::*;
(
    input  logic                 Clk,
    input  logic                 rstN,
    input  logic                 loadEn,     // Program load while ready
    input  logic [AddrWidth-1:0] loadAddr,
    input  logic [DataWidth-1:0] loadData,
    input  logic                 start,
    output logic                 ready,
    output logic                 halt,
    output logic                 outLd,
    output logic [DataWidth-1:0] outData
);

    logic [DataWidth-1:0] src1;
    logic [DataWidth-1:0] src2;
    logic [DataWidth-1:0] aluRes;
    logic [DataWidth-1:0] wbData;

    a09CtrlIf ctrlBus ();

    // ----------------------------------------------------------
    // Decode, execute and fetch/store blocks
    // ----------------------------------------------------------
    sequenceControl uSeq (
        .Clk   (Clk),
        .rstN  (rstN),
        .start (start),
        .ctrl  (ctrlBus.decode),
        .ready (ready),
        .halt  (halt)
    );

    aluExecute uExec (
        .Clk    (Clk),
        .rstN   (rstN),
        .ctrl   (ctrlBus.execute),
        .ir     (ctrlBus.ir),       // Register select fields
        .wbData (wbData),
        .src1   (src1),
        .src2   (src2),
        .aluRes (aluRes)
    );

    fetchStore uFetch (
        .Clk      (Clk),
        .rstN     (rstN),
        .ctrl     (ctrlBus.fetch),
        .src1     (src1),
        .src2     (src2),
        .aluRes   (aluRes),
        .wbData   (wbData),
        .loadEn   (loadEn),
        .loadAddr (loadAddr),
        .loadData (loadData),
        .outLd    (outLd),
        .outData  (outData)
    );

endmodule

/* a09CpuTb.sv */
`timescale 1ns/1ps

module a09CpuTb
    import a09Pkg::*;
();

    localparam int ClkPeriod   = 40;
    localparam int DriveDelay  = 2;      // Inputs change after the edge
    localparam int WaitLimit   = 200;    // Cycles per wait
    localparam int QuietCycles = 50;     // Window after halt

    logic                 Clk;
    logic                 rstN;
    logic                 loadEn;
    logic [AddrWidth-1:0] loadAddr;
    logic [DataWidth-1:0] loadData;
    logic                 start;
    logic                 ready;
    logic                 halt;
    logic                 outLd;
    logic [DataWidth-1:0] outData;

    // Records from the golden file
    logic [AddrWidth-1:0] progAddr [$];
    logic [DataWidth-1:0] progWord [$];
    logic [DataWidth-1:0] expOut [$];
    integer               fd;
    integer               code;
    integer               fieldA;
    integer               fieldB;
    integer               progCount;
    logic [7:0]           tag;
    logic [8*160-1:0]     lineBuf;
    logic                 readDone;
    logic [31:0]          lcgState;

    a09Cpu UUT (
        .Clk      (Clk),
        .rstN     (rstN),
        .loadEn   (loadEn),
        .loadAddr (loadAddr),
        .loadData (loadData),
        .start    (start),
        .ready    (ready),
        .halt     (halt),
        .outLd    (outLd),
        .outData  (outData)
    );

    initial begin
        Clk = 1'b0;
        forever #(ClkPeriod/2) Clk = ~Clk;
    end

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------
    task automatic tick();
        @(posedge Clk);
        #DriveDelay;                     // Drive and sample point
    endtask

    task automatic reportFailure(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic checkEq(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
        if (actual !== expected) begin
            $display("error at %0d ns: %s, got %0h expected %0h",
                     $time, what, actual, expected);
            $display("SOME TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // Numerical Recipes constants
    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic applyReset();
        rstN   = 1'b0;
        loadEn = 1'b0;
        start  = 1'b0;
        repeat (4) tick();
        rstN = 1'b1;
        tick();
        checkEq(ready, 1, "ready after reset");
        checkEq(halt, 0, "halt after reset");
        checkEq(outLd, 0, "outLd after reset");
        checkEq(outData, 0, "outData after reset");
    endtask

    // Writes spaced by 0 to 3 idle cycles
    task automatic loadProgram();
        int idle;
        for (int i = 0; i < progWord.size(); i++) begin
            loadEn   = 1'b1;
            loadAddr = progAddr[i];
            loadData = progWord[i];
            tick();
            loadEn   = 1'b0;
            lcgState = lcgNext(lcgState);
            idle     = lcgState[31:30];
            repeat (idle) tick();
        end
    endtask

    task automatic waitOutLd();
        int cycles;
        cycles = 0;
        while (!outLd && cycles < WaitLimit) begin
            tick();
            cycles++;
        end
        if (!outLd) reportFailure("the outLd pulse never came within the wait limit");
    endtask

    task automatic waitHalt();
        int cycles;
        cycles = 0;
        while (!halt && cycles < WaitLimit) begin
            checkEq(outLd, 0, "outLd beyond the expected outputs");
            tick();
            cycles++;
        end
        if (!halt) reportFailure("halt never came within the wait limit");
    endtask

    // ------------------------------------------------------------
    // One program from reset to halt
    // ------------------------------------------------------------
    task automatic runProgram();
        logic [DataWidth-1:0] expected;
        int                   n;
        n = 0;
        applyReset();
        loadProgram();
        checkEq(ready, 1, "ready after program load");
        start = 1'b1;
        tick();
        start = 1'b0;
        checkEq(ready, 0, "ready after start");
        while (expOut.size() > 0) begin
            expected = expOut.pop_front();
            waitOutLd();
            tick();                      // Output register loads here
            checkEq(outData, expected, $sformatf("output %0d of program %0d", n, progCount));
            n++;
        end
        waitHalt();
        repeat (QuietCycles) begin      // Core must stay stopped
            tick();
            checkEq(outLd, 0, "outLd while halted");
            checkEq(halt, 1, "halt level");
        end
        progAddr.delete();
        progWord.delete();
        progCount++;
    endtask

    initial begin
        rstN      = 1'b0;
        loadEn    = 1'b0;
        loadAddr  = '0;
        loadData  = '0;
        start     = 1'b0;
        lcgState  = 32'h1b0e59e8;
        progCount = 0;
        readDone  = 1'b0;

        fd = $fopen("a09_golden.txt", "r");
        if (fd == 0) reportFailure("could not open a09_golden.txt for reading");

        while (!readDone) begin
            code = $fscanf(fd, " %c", tag);
            if (code != 1) begin
                readDone = 1'b1;         // End of file
            end else begin
                case (tag)
                    "#": ;
                    "P": begin
                        code = $fscanf(fd, "%h %h", fieldA, fieldB);
                        if (code != 2) reportFailure("a P record lacks its address or word");
                        progAddr.push_back(fieldA[AddrWidth-1:0]);
                        progWord.push_back(fieldB[DataWidth-1:0]);
                    end
                    "O": begin
                        code = $fscanf(fd, "%h", fieldB);
                        if (code != 1) reportFailure("an O record lacks its value");
                        expOut.push_back(fieldB[DataWidth-1:0]);
                    end
                    "G": runProgram();
                    default: reportFailure("the golden file holds an unknown record tag");
                endcase
                code = $fgets(lineBuf, fd);    // Drop rest of line
            end
        end
        $fclose(fd);

        checkEq(expOut.size() + progWord.size(), 0, "records left after the last G");
        if (progCount == 0) begin
            reportFailure("the golden file ran no program");
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

/* a09CtrlIf.sv */
`timescale 1ns/1ps

interface a09CtrlIf
    import a09Pkg::*;
();
    // Program flow
    logic                   irLd;
    logic                   pcLd;
    logic                   pcInc;
    PcSrcT                  pcSrc;
    logic                   braSrc;     // 1 = IR offset, 0 = src1 offset
    logic                   stkLd;
    // Memory
    logic                   memEn;
    logic                   memWr;
    AddrSrcT                addrSrc;
    // Register file and ALU
    logic                   regWe;
    DataSrcT                dataSrc;
    aluOpT                  aluOp;
    logic                   aluLd;
    logic                   flgLd;
    logic                   flgRst;
    // Output port
    logic                   outLd;
    logic                   outSel;     // 1 = src1, 0 = memory data
    // Status back to the decoder
    logic [DataWidth-1:0]   ir;
    logic [FlagWidth-1:0]   flags;

    modport decode (
        output irLd, pcLd, pcInc, pcSrc, braSrc, stkLd, memEn, memWr, addrSrc,
        output regWe, dataSrc, aluOp, aluLd, flgLd, flgRst, outLd, outSel,
        input  ir, flags
    );

    modport execute (
        input  regWe, aluOp, aluLd, flgLd, flgRst,
        output flags
    );

    modport fetch (
        input  irLd, pcLd, pcInc, pcSrc, braSrc, stkLd, memEn, memWr, addrSrc,
        input  dataSrc, outLd, outSel,
        output ir
    );

endinterface

/* a09Pkg.sv */
package a09Pkg;

    // ----------------------------------------------------------
    // Widths
    // ----------------------------------------------------------
    localparam int DataWidth   = 16;    // Data path and registers
    localparam int AddrWidth   = 8;     // 256 words of memory
    localparam int RegSelWidth = 3;     // Eight registers
    localparam int FlagWidth   = 4;
    localparam int OpWidth     = 5;     // IR[15:11]
    localparam int AluOpWidth  = 3;

    // Instruction opcodes
    typedef enum logic [OpWidth-1:0] {
        OpNop = 5'd0,
        OpHlt = 5'd1,
        OpLdi = 5'd2,     // Rd = IR[10:8], imm = IR[7:0]
        OpLd  = 5'd3,     // Rd = IR[10:8], addr = IR[7:0]
        OpSt  = 5'd4,     // addr = IR[10:3], data = src1
        OpMov = 5'd5,
        OpAdd = 5'd6,
        OpSub = 5'd7,
        OpAnd = 5'd8,
        OpOr  = 5'd9,
        OpXor = 5'd10,
        OpCmp = 5'd11,    // Flags only
        OpBeq = 5'd12,
        OpBne = 5'd13,
        OpJmp = 5'd14,    // Target in src1
        OpJsr = 5'd15,
        OpRts = 5'd16,
        OpOut = 5'd17
    } opcodeT;

    typedef enum logic [AluOpWidth-1:0] {
        AluAdd  = 3'd0,
        AluSub  = 3'd1,
        AluAnd  = 3'd2,
        AluOr   = 3'd3,
        AluXor  = 3'd4,
        AluPass = 3'd5
    } aluOpT;

    // Flag bit positions
    localparam int FlagZ = 0;
    localparam int FlagC = 1;    // Borrow on subtract
    localparam int FlagN = 2;
    localparam int FlagV = 3;

    // ----------------------------------------------------------
    // Sequencer and datapath selects
    // ----------------------------------------------------------
    typedef enum logic [2:0] {
        StIdle, StFetch, StLoadIr, StDecode, StExec, StMemRd, StWrBack, StHalt
    } seqStateT;

    typedef enum logic [1:0] {AddrPc, AddrSrc2, AddrLow, AddrHigh} AddrSrcT;
    typedef enum logic [1:0] {DataImm, DataMem, DataAlu, DataSrc1} DataSrcT;
    typedef enum logic [1:0] {PcBranch, PcReturn, PcReg, PcZero} PcSrcT;

endpackage

/* a09_golden.txt */
# Records: P <addr> <word> loads a program word, O <value> is the next expected output
# G resets the core, loads the words, starts it and checks the outputs in order
# Arithmetic with 16-bit wraparound
P 00 115A  # LDI r1, 0x5A
P 01 12C3  # LDI r2, 0xC3
P 02 30D1  # ADD r3 = r1 + r2
P 03 8803  # OUT r3
P 04 3911  # SUB r4 = r1 - r2
P 05 8804  # OUT r4
P 06 4151  # AND r5 = r1 & r2
P 07 8805  # OUT r5
P 08 4991  # OR r6 = r1 | r2
P 09 8806  # OUT r6
P 0A 51DC  # XOR r7 = r4 ^ r3
P 0B 2807  # MOV r0 = r7
P 0C 8800  # OUT r0
P 0D 0800  # HLT
O 011D
O FF97
O 0042
O 00DB
O FE8A
G
# Memory round trip through address F0
P 00 11A5  # LDI r1, 0xA5
P 01 127E  # LDI r2, 0x7E
P 02 38CA  # SUB r3 = r2 - r1
P 03 2783  # ST r3 -> [F0]
P 04 1EF0  # LD r6 <- [F0]
P 05 8806  # OUT r6
P 06 0800  # HLT
O FFD9
G
# Branches, r4 marks a wrong path
P 00 1105  # LDI r1, 5
P 01 1205  # LDI r2, 5
P 02 1309  # LDI r3, 9
P 03 14EE  # LDI r4, 0xEE
P 04 5811  # CMP r1, r2
P 05 680E  # BNE 13, falls through
P 06 8801  # OUT r1
P 07 5811  # CMP r1, r2
P 08 6002  # BEQ 0A, taken
P 09 8804  # OUT r4
P 0A 8803  # OUT r3
P 0B 5819  # CMP r1, r3
P 0C 6007  # BEQ 13, falls through
P 0D 8801  # OUT r1
P 0E 5819  # CMP r1, r3
P 0F 6802  # BNE 11, taken
P 10 8804  # OUT r4
P 11 8803  # OUT r3
P 12 0800  # HLT
P 13 8804  # OUT r4
P 14 0800  # HLT
O 0005
O 0009
O 0005
O 0009
G
# Subroutine call and return
P 00 1131  # LDI r1, 0x31
P 01 1242  # LDI r2, 0x42
P 02 7803  # JSR 05
P 03 8802  # OUT r2
P 04 0800  # HLT
P 05 8801  # OUT r1
P 06 8000  # RTS
O 0031
O 0042
G

/* aluExecute.sv */
`timescale 1ns/1ps

module aluExecute
    import a09Pkg::*;
(
    input  logic                 Clk,
    input  logic                 rstN,
    a09CtrlIf.execute            ctrl,
    input  logic [DataWidth-1:0] ir,
    input  logic [DataWidth-1:0] wbData,
    output logic [DataWidth-1:0] src1,
    output logic [DataWidth-1:0] src2,
    output logic [DataWidth-1:0] aluRes
);

    logic [DataWidth-1:0]   regs [2**RegSelWidth];
    logic [RegSelWidth-1:0] destSel;
    opcodeT                 opcode;
    logic [DataWidth-1:0]   aluY;
    logic                   carry;
    logic                   ovf;
    logic [FlagWidth-1:0]   flagsNext;
    logic [FlagWidth-1:0]   flagQ;

    // ----------------------------------------------------------
    // Register file
    // ----------------------------------------------------------
    assign opcode  = opcodeT'(ir[15:11]);
    assign destSel = (opcode == OpLdi || opcode == OpLd) ? ir[10:8] : ir[8:6];

    assign src1 = regs[ir[2:0]];        // Async reads
    assign src2 = regs[ir[5:3]];

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 2**RegSelWidth; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.regWe) begin
            regs[destSel] <= wbData;
        end
    end

    // ----------------------------------------------------------
    // ALU
    // ----------------------------------------------------------
    always_comb begin
        carry = 1'b0;
        ovf   = 1'b0;
        aluY  = src1;
        case (ctrl.aluOp)
            AluAdd: begin
                {carry, aluY} = {1'b0, src1} + {1'b0, src2};
                ovf = (src1[DataWidth-1] == src2[DataWidth-1]) &&
                      (aluY[DataWidth-1] != src1[DataWidth-1]);
            end
            AluSub: begin
                {carry, aluY} = {1'b0, src1} - {1'b0, src2};   // Carry is borrow
                ovf = (src1[DataWidth-1] != src2[DataWidth-1]) &&
                      (aluY[DataWidth-1] != src1[DataWidth-1]);
            end
            AluAnd:  aluY = src1 & src2;
            AluOr:   aluY = src1 | src2;
            AluXor:  aluY = src1 ^ src2;
            default: aluY = src1;         // Pass
        endcase
    end

    always_comb begin
        flagsNext        = '0;
        flagsNext[FlagZ] = (aluY == '0);
        flagsNext[FlagC] = carry;
        flagsNext[FlagN] = aluY[DataWidth-1];
        flagsNext[FlagV] = ovf;
    end

    // Result register feeds writeback one state later
    always_ff @(posedge Clk) begin
        if (ctrl.aluLd) begin
            aluRes <= aluY;
        end
    end

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            flagQ <= '0;
        end else if (ctrl.flgRst) begin
            flagQ <= '0;                  // Cleared after each branch
        end else if (ctrl.flgLd) begin
            flagQ <= flagsNext;
        end
    end

    assign ctrl.flags = flagQ;

    // Writeback of a result never lands in its own ALU cycle
    aRegWeAluLd: assert property (@(posedge Clk) disable iff (!rstN)
        !(ctrl.regWe && ctrl.aluLd));

endmodule

/* fetchStore.sv */
`timescale 1ns/1ps

module fetchStore
    import a09Pkg::*;
(
    input  logic                 Clk,
    input  logic                 rstN,
    a09CtrlIf.fetch              ctrl,
    input  logic [DataWidth-1:0] src1,
    input  logic [DataWidth-1:0] src2,
    input  logic [DataWidth-1:0] aluRes,
    output logic [DataWidth-1:0] wbData,
    input  logic                 loadEn,
    input  logic [AddrWidth-1:0] loadAddr,
    input  logic [DataWidth-1:0] loadData,
    output logic                 outLd,
    output logic [DataWidth-1:0] outData
);

    logic [AddrWidth-1:0] pc;
    logic [AddrWidth-1:0] pcNext;
    logic [AddrWidth-1:0] retAddr;
    logic [DataWidth-1:0] relOffset;
    logic [DataWidth-1:0] braTarget;
    logic [AddrWidth-1:0] memAddr;
    logic [DataWidth-1:0] mem [2**AddrWidth];
    logic [DataWidth-1:0] memQ;
    logic                 memWe;
    logic [AddrWidth-1:0] memWrAddr;
    logic [DataWidth-1:0] memWrData;
    logic [DataWidth-1:0] irQ;

    // ----------------------------------------------------------
    // Program counter and return register
    // ----------------------------------------------------------
    assign relOffset  = {{(DataWidth-8){irQ[7]}}, irQ[7:0]};    // Sign extend
    // PC was bumped in fetch, so step back one word
    assign braTarget  = {{(DataWidth-AddrWidth){1'b0}}, pc} - DataWidth'(1) + relOffset;

    always_comb begin
        case (ctrl.pcSrc)
            PcBranch: pcNext = braTarget[AddrWidth-1:0];
            PcReturn: pcNext = retAddr;
            PcReg:    pcNext = src1[AddrWidth-1:0];    // JMP
            default:  pcNext = '0;                     // Restart
        endcase
    end

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
        end else if (ctrl.pcLd) begin
            pc <= pcNext;
        end else if (ctrl.pcInc) begin
            pc <= pc + 1'b1;
        end
    end

    always_ff @(posedge Clk) begin
        if (ctrl.stkLd) begin
            retAddr <= pc;              // One level only
        end
    end

    // ----------------------------------------------------------
    // Unified memory and IR
    // ----------------------------------------------------------
    always_comb begin
        case (ctrl.addrSrc)
            AddrPc:   memAddr = pc;
            AddrSrc2: memAddr = src2[AddrWidth-1:0];
            AddrLow:  memAddr = irQ[AddrWidth-1:0];
            default:  memAddr = irQ[10:3];             // ST address
        endcase
    end

    // Load port owns the write side while idle
    assign memWe     = loadEn || ctrl.memWr;
    assign memWrAddr = loadEn ? loadAddr : memAddr;
    assign memWrData = loadEn ? loadData : src1;

    always_ff @(posedge Clk) begin
        if (memWe) begin
            mem[memWrAddr] <= memWrData;
        end
        if (ctrl.memEn) begin
            memQ <= mem[memAddr];       // One cycle read
        end
    end

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            irQ <= '0;
        end else if (ctrl.irLd) begin
            irQ <= memQ;
        end
    end

    assign ctrl.ir = irQ;

    // Writeback select
    always_comb begin
        case (ctrl.dataSrc)
            DataImm: wbData = {{(DataWidth-8){1'b0}}, irQ[7:0]};
            DataMem: wbData = memQ;
            DataAlu: wbData = aluRes;
            default: wbData = src1;    // MOV
        endcase
    end

    // ----------------------------------------------------------
    // Output register
    // ----------------------------------------------------------
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            outData <= '0;
        end else if (ctrl.outLd) begin
            outData <= src1;
        end
    end

    assign outLd = ctrl.outLd;

    aPcLdInc: assert property (@(posedge Clk) disable iff (!rstN)
        !(ctrl.pcLd && ctrl.pcInc));

endmodule

/* project.f */
a09Pkg.sv
a09CtrlIf.sv
sequenceControl.sv
aluExecute.sv
fetchStore.sv
a09Cpu.sv
a09CpuTb.sv

/* sequenceControl.sv */
`timescale 1ns/1ps

module sequenceControl
    import a09Pkg::*;
(
    input  logic     Clk,
    input  logic     rstN,
    input  logic     start,
    a09CtrlIf.decode ctrl,
    output logic     ready,
    output logic     halt
);

    seqStateT state;
    seqStateT stateNext;
    opcodeT   opcode;
    logic     zero;

    assign opcode = opcodeT'(ctrl.ir[15:11]);
    assign zero   = ctrl.flags[FlagZ];

    assign ready = (state == StIdle);
    assign halt  = (state == StHalt);

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            state <= StIdle;
        end else begin
            state <= stateNext;
        end
    end

    // ----------------------------------------------------------
    // Strobe pattern per state
    // ----------------------------------------------------------
    always_comb begin
        stateNext    = state;
        ctrl.irLd    = 1'b0;
        ctrl.pcLd    = 1'b0;
        ctrl.pcInc   = 1'b0;
        ctrl.pcSrc   = PcBranch;
        ctrl.braSrc  = 1'b1;
        ctrl.stkLd   = 1'b0;
        ctrl.memEn   = 1'b0;
        ctrl.memWr   = 1'b0;
        ctrl.addrSrc = AddrPc;
        ctrl.regWe   = 1'b0;
        ctrl.dataSrc = DataImm;
        ctrl.aluOp   = AluPass;
        ctrl.aluLd   = 1'b0;
        ctrl.flgLd   = 1'b0;
        ctrl.flgRst  = 1'b0;
        ctrl.outLd   = 1'b0;
        ctrl.outSel  = 1'b1;

        case (state)
            StIdle, StHalt: begin
                if (start) begin              // Restart at address 0
                    ctrl.pcLd   = 1'b1;
                    ctrl.pcSrc  = PcZero;
                    ctrl.flgRst = 1'b1;
                    stateNext   = StFetch;
                end
            end
            StFetch: begin
                ctrl.memEn = 1'b1;            // Read at PC
                ctrl.pcInc = 1'b1;
                stateNext  = StLoadIr;
            end
            StLoadIr: begin
                ctrl.irLd = 1'b1;             // Memory data now valid
                stateNext = StDecode;
            end
            StDecode: stateNext = StExec;     // IR settles into decode
            StExec: begin
                stateNext = StFetch;          // Most opcodes finish here
                case (opcode)
                    OpNop: ;
                    OpHlt: stateNext = StHalt;
                    OpLdi: ctrl.regWe = 1'b1;
                    OpLd: begin
                        ctrl.memEn   = 1'b1;
                        ctrl.addrSrc = AddrLow;
                        stateNext    = StMemRd;
                    end
                    OpSt: begin
                        ctrl.memWr   = 1'b1;
                        ctrl.addrSrc = AddrHigh;
                    end
                    OpMov: begin
                        ctrl.regWe   = 1'b1;
                        ctrl.dataSrc = DataSrc1;
                    end
                    OpAdd, OpSub, OpAnd, OpOr, OpXor: begin
                        ctrl.aluLd = 1'b1;
                        ctrl.flgLd = 1'b1;
                        stateNext  = StWrBack;
                        case (opcode)
                            OpAdd:   ctrl.aluOp = AluAdd;
                            OpSub:   ctrl.aluOp = AluSub;
                            OpAnd:   ctrl.aluOp = AluAnd;
                            OpOr:    ctrl.aluOp = AluOr;
                            default: ctrl.aluOp = AluXor;
                        endcase
                    end
                    OpCmp: begin
                        ctrl.aluOp = AluSub;      // Flags only, no writeback
                        ctrl.flgLd = 1'b1;
                    end
                    OpBeq, OpBne: begin
                        ctrl.pcLd   = (opcode == OpBeq) ? zero : !zero;
                        ctrl.flgRst = 1'b1;       // Flags consumed by branch
                    end
                    OpJmp: begin
                        ctrl.pcLd  = 1'b1;
                        ctrl.pcSrc = PcReg;
                    end
                    OpJsr: begin
                        ctrl.pcLd  = 1'b1;
                        ctrl.stkLd = 1'b1;        // PC already points past JSR
                    end
                    OpRts: begin
                        ctrl.pcLd  = 1'b1;
                        ctrl.pcSrc = PcReturn;
                    end
                    OpOut: ctrl.outLd = 1'b1;
                    default: stateNext = StHalt;  // Illegal opcode stops core
                endcase
            end
            StMemRd: begin
                ctrl.regWe   = 1'b1;
                ctrl.dataSrc = DataMem;
                stateNext    = StFetch;
            end
            StWrBack: begin
                ctrl.regWe   = 1'b1;
                ctrl.dataSrc = DataAlu;
                stateNext    = StFetch;
            end
            default: stateNext = StIdle;
        endcase
    end

    // Store cycle can never overlap an instruction load
    aMemWrIrLd: assert property (@(posedge Clk) disable iff (!rstN)
        !(ctrl.memWr && ctrl.irLd));

    // Output strobe is a single-cycle pulse
    aOutLdPulse: assert property (@(posedge Clk) disable iff (!rstN)
        ctrl.outLd |=> !ctrl.outLd);

endmodule
